//--- source/serdes_macros.svh
`ifndef SERDES_MACROS_SVH
`define SERDES_MACROS_SVH

// link word width
`define WORD_BITS 11

// packet fields
`define CODE_BITS 8
`define DATA_BITS 24
`define ROUTE_BITS 10 // appended by the tagger

// words per packet on the link, lsw first
`define IN_WORDS 3 // 33 bits, 1 pad
`define OUT_WORDS 4 // 44 bits, 2 pad

// buffer depths
`define WORD_FIFO_DEPTH 8
`define PACKET_FIFO_DEPTH 4

`endif

//--- source/serdesPkg.sv
`default_nettype none

`include "serdes_macros.svh"

package serdesPkg;

	// one word on the 11-bit link
	typedef logic [`WORD_BITS-1:0] wordT;

	// inbound packet, code sits in the msbs
	typedef struct packed {
		logic [`CODE_BITS-1:0] code; // selects the route
		logic [`DATA_BITS-1:0] data; // payload, untouched
	} inPacketT;

	// outbound packet, route appended below data
	typedef struct packed {
		logic [`CODE_BITS-1:0]  code;
		logic [`DATA_BITS-1:0]  data;
		logic [`ROUTE_BITS-1:0] route; // from the route table
	} outPacketT;

endpackage

`default_nettype wire

//--- source/wordFifo.sv
`default_nettype none
`timescale 1ns/100ps

module wordFifo #(
	parameter type payloadT = logic [7:0],
	parameter int depth = 4
) (
	input  logic    clk,
	input  logic    arstN,
	input  payloadT inData,
	input  logic    inValid,
	output logic    inReady,
	output payloadT outData,
	output logic    outValid,
	input  logic    outReady
);

	// pointer and count widths, guard depth of 1
	localparam int ptrBits = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntBits = $clog2(depth + 1);

	payloadT mem [depth]; // circular storage
	logic [ptrBits-1:0] wrPtr; // next slot to fill
	logic [ptrBits-1:0] rdPtr; // head entry
	logic [cntBits-1:0] count; // occupancy
	logic full;
	logic wrEn;
	logic rdEn;

	// wraps at depth, not at a power of two
	function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] ptr);
		logic [ptrBits-1:0] result;
		if (ptr == ptrBits'(depth - 1)) begin
			result = '0;
		end else begin
			result = ptr + 1'b1;
		end
		return result;
	endfunction

	assign full = (count == cntBits'(depth));
	assign outValid = (count != '0); // registered state only
	assign outData = mem[rdPtr]; // head visible the cycle after a write
	assign inReady = !full || outReady; // full fifo still takes a word when one leaves

	assign wrEn = inValid && inReady;
	assign rdEn = outValid && outReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (wrEn) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (rdEn) begin
				rdPtr <= nextPtr(rdPtr);
			end
			// count only moves on an unbalanced cycle
			if (wrEn && !rdEn) begin
				count <= count + 1'b1;
			end else if (rdEn && !wrEn) begin
				count <= count - 1'b1;
			end
		end
	end

	// storage write
	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[wrPtr] <= inData;
		end
	end

endmodule

`default_nettype wire

//--- source/packetDeserializer.sv
`default_nettype none
`timescale 1ns/100ps

`include "serdes_macros.svh"

module packetDeserializer (
	input  logic                clk,
	input  logic                arstN,
	input  serdesPkg::wordT     inWord,
	input  logic                inValid,
	output logic                inReady,
	output serdesPkg::inPacketT outPacket,
	output logic                outValid,
	input  logic                outReady
);

	import serdesPkg::*;

	localparam int asmBits = `IN_WORDS * `WORD_BITS; // 33 incl. pad
	localparam int pktBits = $bits(inPacketT); // 32
	localparam int cntBits = $clog2(`IN_WORDS);
	localparam logic [cntBits-1:0] lastWord = cntBits'(`IN_WORDS - 1);

	logic [asmBits-1:0] asmReg; // words land lsw first
	logic [cntBits-1:0] wordCnt; // slot for the next word
	logic accept;
	logic taken;

	// held packet blocks input until it leaves
	// in the take cycle the next first word may come in
	assign inReady = !outValid || outReady;
	assign accept = inValid && inReady;
	assign taken = outValid && outReady;

	// drop the pad bit at the top of the last word
	assign outPacket = inPacketT'(asmReg[pktBits-1:0]);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wordCnt <= '0;
			outValid <= 1'b0;
		end else begin
			if (accept) begin
				if (wordCnt == lastWord) begin
					wordCnt <= '0;
					outValid <= 1'b1; // third word completes the packet
				end else begin
					wordCnt <= wordCnt + 1'b1;
					if (taken) begin
						outValid <= 1'b0;
					end
				end
			end else if (taken) begin
				outValid <= 1'b0;
			end
		end
	end

	// word goes into its own slice
	// a first word during a take overwrites slice 0 after it is sampled
	always_ff @(posedge clk) begin
		if (accept) begin
			asmReg[wordCnt * `WORD_BITS +: `WORD_BITS] <= inWord;
		end
	end

endmodule

`default_nettype wire

//--- source/routeTagger.sv
`default_nettype none
`timescale 1ns/100ps

`include "serdes_macros.svh"

module routeTagger (
	input  logic                    clk,
	input  logic                    arstN,
	input  logic                    cfgValid,
	input  logic [`CODE_BITS-1:0]   cfgCode,
	input  logic [`ROUTE_BITS-1:0]  cfgRoute,
	input  serdesPkg::inPacketT     inPacket,
	input  logic                    inValid,
	output logic                    inReady,
	output serdesPkg::outPacketT    outPacket,
	output logic                    outValid,
	input  logic                    outReady
);

	import serdesPkg::*;

	localparam int tableSize = 1 << `CODE_BITS; // one entry per code

	logic [`ROUTE_BITS-1:0] routeTable [tableSize];
	logic [`ROUTE_BITS-1:0] lookupRoute; // route for the offered packet
	logic accept;

	// register empty or emptying this cycle
	assign inReady = !outValid || outReady;
	assign accept = inValid && inReady;

	// table read before the edge, so a same-cycle write is not seen
	assign lookupRoute = routeTable[inPacket.code];

	// host programming, one entry per cfgValid edge
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < tableSize; i++) begin
				routeTable[i] <= '0; // unwritten codes route to zero
			end
		end else if (cfgValid) begin
			routeTable[cfgCode] <= cfgRoute;
		end
	end

	// output stage valid
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
		end else if (accept) begin
			outValid <= 1'b1;
		end else if (outReady) begin
			outValid <= 1'b0; // drained, nothing new
		end
	end

	// code and data pass straight through, route appended
	always_ff @(posedge clk) begin
		if (accept) begin
			outPacket.code <= inPacket.code;
			outPacket.data <= inPacket.data;
			outPacket.route <= lookupRoute;
		end
	end

endmodule

`default_nettype wire

//--- source/packetSerializer.sv
`default_nettype none
`timescale 1ns/100ps

`include "serdes_macros.svh"

module packetSerializer (
	input  logic                 clk,
	input  logic                 arstN,
	input  serdesPkg::outPacketT inPacket,
	input  logic                 inValid,
	output logic                 inReady,
	output serdesPkg::wordT      outWord,
	output logic                 outValid,
	input  logic                 outReady
);

	import serdesPkg::*;

	localparam int outBits = `OUT_WORDS * `WORD_BITS; // 44
	localparam int padBits = outBits - $bits(outPacketT); // 2
	localparam int idxBits = $clog2(`OUT_WORDS);
	localparam logic [idxBits-1:0] lastWord = idxBits'(`OUT_WORDS - 1);

	logic [outBits-1:0] shiftReg; // padded copy of the packet
	logic [idxBits-1:0] wordIdx; // slice currently offered
	logic lastTaken; // fourth word leaves this cycle
	logic load;
	logic advance;

	assign advance = outValid && outReady;
	assign lastTaken = advance && (wordIdx == lastWord);

	// idle, or reload right as the last word goes
	assign inReady = !outValid || lastTaken;
	assign load = inValid && inReady;

	// lsw first
	assign outWord = shiftReg[wordIdx * `WORD_BITS +: `WORD_BITS];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wordIdx <= '0;
			outValid <= 1'b0;
		end else begin
			if (load) begin
				wordIdx <= '0; // restart at the low word
				outValid <= 1'b1;
			end else if (lastTaken) begin
				wordIdx <= '0;
				outValid <= 1'b0; // nothing queued behind
			end else if (advance) begin
				wordIdx <= wordIdx + 1'b1;
			end
		end
	end

	// pad bits end up in the top of the fourth word
	always_ff @(posedge clk) begin
		if (load) begin
			shiftReg <= {{padBits{1'b0}}, inPacket};
		end
	end

endmodule

`default_nettype wire

//--- source/serdesTop.sv
`default_nettype none
`timescale 1ns/100ps

`include "serdes_macros.svh"

module serdesTop (
	input  logic                   clk,
	input  logic                   arstN,
	input  serdesPkg::wordT        inWord,
	input  logic                   inValid,
	output logic                   inReady,
	output serdesPkg::wordT        outWord,
	output logic                   outValid,
	input  logic                   outReady,
	input  logic                   cfgValid,
	input  logic [`CODE_BITS-1:0]  cfgCode,
	input  logic [`ROUTE_BITS-1:0] cfgRoute
);

	import serdesPkg::*;

	wordT bufWord; // input fifo to deserializer
	logic bufValid;
	logic bufReady;

	inPacketT desPacket; // deserializer to packet fifo
	logic desValid;
	logic desReady;

	inPacketT fifoPacket; // packet fifo to tagger
	logic fifoPacketValid;
	logic fifoPacketReady;

	outPacketT tagPacket; // tagger to serializer
	logic tagValid;
	logic tagReady;

	wordT serWord; // serializer to output fifo
	logic serValid;
	logic serReady;

	// link words in
	wordFifo #(.payloadT(wordT), .depth(`WORD_FIFO_DEPTH)) inWordFifo (
		.clk(clk), .arstN(arstN),
		.inData(inWord), .inValid(inValid), .inReady(inReady),
		.outData(bufWord), .outValid(bufValid), .outReady(bufReady)
	);

	packetDeserializer deser (
		.clk(clk), .arstN(arstN),
		.inWord(bufWord), .inValid(bufValid), .inReady(bufReady),
		.outPacket(desPacket), .outValid(desValid), .outReady(desReady)
	);

	wordFifo #(.payloadT(inPacketT), .depth(`PACKET_FIFO_DEPTH)) packetFifo (
		.clk(clk), .arstN(arstN),
		.inData(desPacket), .inValid(desValid), .inReady(desReady),
		.outData(fifoPacket), .outValid(fifoPacketValid), .outReady(fifoPacketReady)
	);

	routeTagger tagger (
		.clk(clk), .arstN(arstN),
		.cfgValid(cfgValid), .cfgCode(cfgCode), .cfgRoute(cfgRoute),
		.inPacket(fifoPacket), .inValid(fifoPacketValid), .inReady(fifoPacketReady),
		.outPacket(tagPacket), .outValid(tagValid), .outReady(tagReady)
	);

	packetSerializer ser (
		.clk(clk), .arstN(arstN),
		.inPacket(tagPacket), .inValid(tagValid), .inReady(tagReady),
		.outWord(serWord), .outValid(serValid), .outReady(serReady)
	);

	// link words out
	wordFifo #(.payloadT(wordT), .depth(`WORD_FIFO_DEPTH)) outWordFifo (
		.clk(clk), .arstN(arstN),
		.inData(serWord), .inValid(serValid), .inReady(serReady),
		.outData(outWord), .outValid(outValid), .outReady(outReady)
	);

endmodule

`default_nettype wire

//--- testbench/serdesTopTb.sv
`default_nettype none
`timescale 1ns/100ps

`include "serdes_macros.svh"

module serdesTopTb;

	import serdesPkg::*;

	localparam int numRoutes = 6;
	localparam int numRows = 8;
	localparam int totalPackets = numRows * 4; // round trip, two back-pressure passes, random
	localparam int cycleLimit = 40 * totalPackets + 200;

	logic clk;
	logic arstN;
	wordT inWord;
	logic inValid;
	logic inReady;
	wordT outWord;
	logic outValid;
	logic outReady;
	logic cfgValid;
	logic [`CODE_BITS-1:0] cfgCode;
	logic [`ROUTE_BITS-1:0] cfgRoute;

	// route programming table, code 22 written twice
	logic [`CODE_BITS-1:0] routeCode [0:numRoutes-1] = '{8'h11, 8'h22, 8'h3c, 8'h80, 8'h22, 8'hff};
	logic [`ROUTE_BITS-1:0] routeVal [0:numRoutes-1] = '{10'h155, 10'h2aa, 10'h0f0, 10'h001,
		10'h31c, 10'h3ff};

	// packet table, 5a is never configured
	logic [`CODE_BITS-1:0] pktCode [0:numRows-1] = '{8'h11, 8'h22, 8'h3c, 8'h5a, 8'h80, 8'hff,
		8'h22, 8'h11};
	logic [`DATA_BITS-1:0] pktData [0:numRows-1] = '{24'h123456, 24'habcdef, 24'h000001,
		24'hfffffe, 24'h5a5a5a, 24'h800000, 24'h00ff00, 24'h7fffff};

	logic [`ROUTE_BITS-1:0] routeModel [0:(1 << `CODE_BITS)-1]; // tb copy of the table
	wordT expQ [$]; // expected outbound words in order
	int errorCount;
	int checkCount;
	int cycleCount;
	logic sendDone; // sender thread finished its pass
	logic sawStall; // inReady seen low under back-pressure

	serdesTop UUT (
		.clk(clk), .arstN(arstN),
		.inWord(inWord), .inValid(inValid), .inReady(inReady),
		.outWord(outWord), .outValid(outValid), .outReady(outReady),
		.cfgValid(cfgValid), .cfgCode(cfgCode), .cfgRoute(cfgRoute)
	);

	always #50 clk = ~clk; // 100 ns period

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			$display("ERROR at %0t: %s actual %h expected %h", $time, name, actual, expected);
			errorCount++;
		end
	endtask

	task automatic reportProblem(input string msg);
		$display("%0t: %s", $time, msg);
		errorCount++;
	endtask

	// code and data, one pad bit on top, lsw first
	function automatic wordT inWordOf(input logic [`CODE_BITS-1:0] code,
		input logic [`DATA_BITS-1:0] data, input int idx);
		logic [`IN_WORDS*`WORD_BITS-1:0] bits;
		bits = '0;
		bits[`CODE_BITS+`DATA_BITS-1:0] = {code, data};
		return bits[idx*`WORD_BITS +: `WORD_BITS];
	endfunction

	// code, data, route, two pad bits on top
	function automatic wordT outWordOf(input logic [`CODE_BITS-1:0] code,
		input logic [`DATA_BITS-1:0] data, input logic [`ROUTE_BITS-1:0] route, input int idx);
		logic [`OUT_WORDS*`WORD_BITS-1:0] bits;
		bits = '0;
		bits[`CODE_BITS+`DATA_BITS+`ROUTE_BITS-1:0] = {code, data, route};
		return bits[idx*`WORD_BITS +: `WORD_BITS];
	endfunction

	// one table write per cycle, called at edge plus 10
	task automatic writeRoute(input logic [`CODE_BITS-1:0] code,
		input logic [`ROUTE_BITS-1:0] route);
		cfgValid = 1'b1;
		cfgCode = code;
		cfgRoute = route;
		routeModel[code] = route; // last write wins
		@(posedge clk);
		#10;
		cfgValid = 1'b0;
	endtask

	task automatic sendWord(input wordT w);
		if ($urandom % 4 == 0) begin
			inValid = 1'b0; // random idle cycle
			@(posedge clk);
			#10;
		end
		inWord = w;
		inValid = 1'b1;
		@(negedge clk);
		while (!inReady) @(negedge clk); // hold until accepted
		@(posedge clk);
		#10;
	endtask

	task automatic sendPacket(input int row);
		logic [`ROUTE_BITS-1:0] route;
		route = routeModel[pktCode[row]]; // zero if never written
		for (int i = 0; i < `OUT_WORDS; i++) begin
			expQ.push_back(outWordOf(pktCode[row], pktData[row], route, i));
		end
		for (int i = 0; i < `IN_WORDS; i++) begin
			sendWord(inWordOf(pktCode[row], pktData[row], i));
		end
	endtask

	task automatic sendTable();
		for (int r = 0; r < numRows; r++) begin
			sendPacket(r);
		end
		inValid = 1'b0;
	endtask

	task automatic waitDrain();
		while (expQ.size() != 0) @(negedge clk);
		@(posedge clk);
		#10;
	endtask

	// output monitor, negedge values match the next edge
	always @(negedge clk) begin
		if (arstN && outValid && outReady) begin
			if (expQ.size() == 0) begin
				reportProblem("output word appeared with nothing expected");
			end else begin
				checkValue("outWord", outWord, expQ.pop_front());
			end
		end
	end

	// timeout
	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("run stopped after %0d cycles without finishing the tests", cycleCount);
			$display("checks %0d, errors %0d", checkCount, errorCount + 1);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		inWord = '0;
		inValid = 1'b0;
		outReady = 1'b0;
		cfgValid = 1'b0;
		cfgCode = '0;
		cfgRoute = '0;
		errorCount = 0;
		checkCount = 0;
		cycleCount = 0;
		sendDone = 1'b0;
		sawStall = 1'b0;
		void'($urandom(50)); // seed once
		for (int i = 0; i < (1 << `CODE_BITS); i++) routeModel[i] = '0;

		// reset for 4 cycles
		repeat (2) @(negedge clk);
		checkValue("outValid", outValid, 0);
		repeat (2) @(posedge clk);
		#10;
		arstN = 1'b1;
		@(negedge clk);
		checkValue("outValid", outValid, 0);
		checkValue("inReady", inReady, 1);
		@(posedge clk);
		#10;

		// program routes
		for (int i = 0; i < numRoutes; i++) begin
			writeRoute(routeCode[i], routeVal[i]);
		end

		// round trip with free output
		outReady = 1'b1;
		sendTable();
		waitDrain();

		// back-pressure, two passes so all buffering fills
		outReady = 1'b0;
		sendDone = 1'b0;
		sawStall = 1'b0;
		fork
			begin
				sendTable();
				sendTable();
				sendDone = 1'b1;
			end
			begin
				while (!sawStall && !sendDone) begin
					@(negedge clk);
					if (!inReady) sawStall = 1'b1;
				end
				if (!sawStall) reportProblem("inReady never fell while outReady was held low");
				repeat (20) @(posedge clk); // stay stalled a while
				#10;
				outReady = 1'b1;
			end
		join
		waitDrain();

		// random output ready over a full pass
		sendDone = 1'b0;
		fork
			begin
				sendTable();
				sendDone = 1'b1;
			end
			begin
				while (!sendDone) begin
					@(posedge clk);
					#10;
					outReady = $urandom % 2;
				end
			end
		join
		outReady = 1'b1;
		waitDrain();

		// idle, no extra words allowed, pipeline must be empty
		repeat (50) @(posedge clk);
		@(negedge clk);
		checkValue("outValid", outValid, 0);
		checkValue("inReady", inReady, 1);

		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- coreSerdes.f
+incdir+source
source/serdesPkg.sv
source/wordFifo.sv
source/packetDeserializer.sv
source/routeTagger.sv
source/packetSerializer.sv
source/serdesTop.sv
testbench/serdesTopTb.sv
